/* Bender.yml */
package:
  name: gat_attn

sources:
  - include_dirs:
      - hw
    files:
      - hw/gat_cmd_pkg.sv
      - hw/gat_data_pkg.sv
      - hw/gat_cmd_decode.sv
      - hw/gat_attention_score.sv
      - hw/gat_aggregator.sv
      - hw/gat_attn_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/tb_clock_gen.sv
      - sim/gat_attn_assertions.sv
      - sim/gat_attn_tb.sv

/* files.f */
+incdir+hw
hw/gat_cmd_pkg.sv
hw/gat_data_pkg.sv
hw/gat_cmd_decode.sv
hw/gat_attention_score.sv
hw/gat_aggregator.sv
hw/gat_attn_top.sv
sim/tb_clock_gen.sv
sim/gat_attn_assertions.sv
sim/gat_attn_tb.sv

/* hw/gat_aggregator.sv */
`include "gat_config.svh"

module gat_aggregator
  import gat_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  input  logic      cf_valid_i,
  output logic      cf_ready_o,
  input  coef_t     cf_coef_i,
  input  feat_vec_t cf_feat_i,
  input  logic      cf_last_i,

  output logic      out_valid_o,
  input  logic      out_ready_i,
  output acc_vec_t  out_data_o,

  output logic      busy_o
);

  acc_vec_t acc_q;
  acc_vec_t acc_next;
  logic     acc_active;
  logic     cf_fire;

  // Result register must drain before the next item is taken
  assign cf_ready_o = !out_valid_o;
  assign cf_fire    = cf_valid_i && cf_ready_o;
  assign busy_o     = acc_active || out_valid_o;

  always_comb begin
    for (int k = 0; k < `GAT_NUM_FEAT; k++) begin
      acc_next[k] = acc_q[k] + cf_coef_i * cf_feat_i[k];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q       <= '0;
      acc_active  <= 1'b0;
      out_valid_o <= 1'b0;
    end else begin
      if (out_valid_o && out_ready_i) begin
        out_valid_o <= 1'b0;
      end
      if (cf_fire) begin
        if (cf_last_i) begin
          acc_q       <= '0;
          acc_active  <= 1'b0;
          out_valid_o <= 1'b1;
        end else begin
          acc_q      <= acc_next;
          acc_active <= 1'b1;
        end
      end
    end
  end

  // Final sum includes the last neighbour
  always_ff @(posedge clk) begin
    if (cf_fire && cf_last_i) begin
      out_data_o <= acc_next;
    end
  end

endmodule

/* hw/gat_attention_score.sv */
`include "gat_config.svh"

module gat_attention_score
  import gat_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  input  logic      nb_valid_i,
  output logic      nb_ready_o,
  input  feat_vec_t nb_target_i,
  input  feat_vec_t nb_feat_i,
  input  logic      nb_last_i,
  input  feat_vec_t a_self_i,
  input  feat_vec_t a_neigh_i,

  output logic      cf_valid_o,
  input  logic      cf_ready_i,
  output coef_t     cf_coef_o,
  output feat_vec_t cf_feat_o,
  output logic      cf_last_o,

  output logic      busy_o
);

  localparam coef_t COEF_MAX = {1'b0, {(`GAT_COEF_W-1){1'b1}}};
  localparam coef_t COEF_MIN = {1'b1, {(`GAT_COEF_W-1){1'b0}}};

  function automatic score_t dot4(input feat_vec_t a, input feat_vec_t b);
    score_t sum;
    sum = '0;
    for (int k = 0; k < `GAT_NUM_FEAT; k++) begin
      sum = sum + a[k] * b[k];
    end
    return sum;
  endfunction

  logic      s1_valid;
  score_t    s1_dot_self;
  score_t    s1_dot_neigh;
  feat_vec_t s1_feat;
  logic      s1_last;
  logic      nb_fire;
  logic      s2_load;

  // One extra bit so the two halves can be added without wrapping
  logic signed [`GAT_SCORE_W:0] raw_sum;
  logic signed [`GAT_SCORE_W:0] leaky;
  logic signed [`GAT_SCORE_W:0] scaled;
  coef_t                        coef_sat;

  assign s2_load    = s1_valid && (!cf_valid_o || cf_ready_i);
  assign nb_ready_o = !s1_valid || !cf_valid_o || cf_ready_i;
  assign nb_fire    = nb_valid_i && nb_ready_o;
  assign busy_o     = s1_valid || cf_valid_o;

  always_comb begin
    raw_sum = s1_dot_self + s1_dot_neigh;
    leaky   = raw_sum[`GAT_SCORE_W] ? (raw_sum >>> `GAT_LEAKY_SHIFT) : raw_sum;
    scaled  = leaky >>> `GAT_SCORE_SHIFT;
    if (scaled > COEF_MAX) begin
      coef_sat = COEF_MAX;
    end else if (scaled < COEF_MIN) begin
      coef_sat = COEF_MIN;
    end else begin
      coef_sat = coef_t'(scaled);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid   <= 1'b0;
      cf_valid_o <= 1'b0;
    end else begin
      if (nb_fire) begin
        s1_valid <= 1'b1;
      end else if (s2_load) begin
        s1_valid <= 1'b0;
      end
      if (s2_load) begin
        cf_valid_o <= 1'b1;
      end else if (cf_ready_i) begin
        cf_valid_o <= 1'b0;
      end
    end
  end

  // Stage 1 dot products, stage 2 activation
  always_ff @(posedge clk) begin
    if (nb_fire) begin
      s1_dot_self  <= dot4(a_self_i, nb_target_i);
      s1_dot_neigh <= dot4(a_neigh_i, nb_feat_i);
      s1_feat      <= nb_feat_i;
      s1_last      <= nb_last_i;
    end
    if (s2_load) begin
      cf_coef_o <= coef_sat;
      cf_feat_o <= s1_feat;
      cf_last_o <= s1_last;
    end
  end

endmodule

/* hw/gat_attn_top.sv */
module gat_attn_top
  import gat_cmd_pkg::*;
  import gat_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  input  logic      cmd_valid_i,
  output logic      cmd_ready_o,
  input  gat_op_e   cmd_op_i,
  input  feat_vec_t cmd_data_i,

  output logic      out_valid_o,
  input  logic      out_ready_i,
  output acc_vec_t  out_data_o
);

  logic      nb_valid;
  logic      nb_ready;
  feat_vec_t nb_target;
  feat_vec_t nb_feat;
  logic      nb_last;
  feat_vec_t a_self;
  feat_vec_t a_neigh;

  logic      cf_valid;
  logic      cf_ready;
  coef_t     cf_coef;
  feat_vec_t cf_feat;
  logic      cf_last;

  logic      score_busy;
  logic      aggr_busy;

  gat_cmd_decode u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_op_i    (cmd_op_i),
    .cmd_data_i  (cmd_data_i),
    .nb_valid_o  (nb_valid),
    .nb_ready_i  (nb_ready),
    .nb_target_o (nb_target),
    .nb_feat_o   (nb_feat),
    .nb_last_o   (nb_last),
    .a_self_o    (a_self),
    .a_neigh_o   (a_neigh),
    .busy_i      (score_busy | aggr_busy)
  );

  gat_attention_score u_score (
    .clk         (clk),
    .rst_n       (rst_n),
    .nb_valid_i  (nb_valid),
    .nb_ready_o  (nb_ready),
    .nb_target_i (nb_target),
    .nb_feat_i   (nb_feat),
    .nb_last_i   (nb_last),
    .a_self_i    (a_self),
    .a_neigh_i   (a_neigh),
    .cf_valid_o  (cf_valid),
    .cf_ready_i  (cf_ready),
    .cf_coef_o   (cf_coef),
    .cf_feat_o   (cf_feat),
    .cf_last_o   (cf_last),
    .busy_o      (score_busy)
  );

  gat_aggregator u_aggregator (
    .clk         (clk),
    .rst_n       (rst_n),
    .cf_valid_i  (cf_valid),
    .cf_ready_o  (cf_ready),
    .cf_coef_i   (cf_coef),
    .cf_feat_i   (cf_feat),
    .cf_last_i   (cf_last),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data_o),
    .busy_o      (aggr_busy)
  );

endmodule

/* hw/gat_cmd_decode.sv */
`include "gat_config.svh"

module gat_cmd_decode
  import gat_cmd_pkg::*;
  import gat_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  input  logic      cmd_valid_i,
  output logic      cmd_ready_o,
  input  gat_op_e   cmd_op_i,
  input  feat_vec_t cmd_data_i,

  output logic      nb_valid_o,
  input  logic      nb_ready_i,
  output feat_vec_t nb_target_o,
  output feat_vec_t nb_feat_o,
  output logic      nb_last_o,
  output feat_vec_t a_self_o,
  output feat_vec_t a_neigh_o,

  input  logic      busy_i
);

  localparam int CNT_W = $clog2(`GAT_MAX_NEIGH);

  dec_state_e       state_q;
  logic [CNT_W-1:0] nb_cnt_q;
  logic             cmd_fire;
  logic             is_set;
  logic             is_neigh;
  logic             nb_stall;
  logic             nb_issue;
  logic             nb_is_last;

  assign is_set   = (cmd_op_i == OP_SET_A_SELF) || (cmd_op_i == OP_SET_A_NEIGH);
  assign is_neigh = (cmd_op_i == OP_NEIGH) || (cmd_op_i == OP_NEIGH_LAST);
  assign nb_stall = nb_valid_o && !nb_ready_i;

  // Attention halves may only change once the score pipeline has drained
  assign cmd_ready_o = !nb_stall && !(is_set && (busy_i || nb_valid_o));
  assign cmd_fire    = cmd_valid_i && cmd_ready_o;

  // Neighbours outside a subgraph are swallowed
  assign nb_issue   = cmd_fire && is_neigh && (state_q == ST_COLLECT);
  assign nb_is_last = (cmd_op_i == OP_NEIGH_LAST) ||
                      (nb_cnt_q == CNT_W'(`GAT_MAX_NEIGH - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= ST_IDLE;
      nb_cnt_q   <= '0;
      nb_valid_o <= 1'b0;
      a_self_o   <= '0;
      a_neigh_o  <= '0;
    end else begin
      if (nb_valid_o && nb_ready_i) begin
        nb_valid_o <= 1'b0;
      end
      if (nb_issue) begin
        nb_valid_o <= 1'b1;
        if (nb_is_last) begin
          state_q  <= ST_IDLE;
          nb_cnt_q <= '0;
        end else begin
          nb_cnt_q <= nb_cnt_q + 1'b1;
        end
      end
      if (cmd_fire) begin
        case (cmd_op_i)
          OP_SET_A_SELF:  a_self_o  <= cmd_data_i;
          OP_SET_A_NEIGH: a_neigh_o <= cmd_data_i;
          OP_TARGET: begin
            state_q  <= ST_COLLECT;
            nb_cnt_q <= '0;
          end
          default: ;
        endcase
      end
    end
  end

  // Work item payload
  always_ff @(posedge clk) begin
    if (cmd_fire && cmd_op_i == OP_TARGET) begin
      nb_target_o <= cmd_data_i;
    end
    if (nb_issue) begin
      nb_feat_o <= cmd_data_i;
      nb_last_o <= nb_is_last;
    end
  end

endmodule

/* hw/gat_cmd_pkg.sv */
package gat_cmd_pkg;

  // Command stream opcodes
  typedef enum logic [2:0] {
    OP_NOP         = 3'd0,
    OP_SET_A_SELF  = 3'd1,
    OP_SET_A_NEIGH = 3'd2,
    OP_TARGET      = 3'd3,
    OP_NEIGH       = 3'd4,
    OP_NEIGH_LAST  = 3'd5
  } gat_op_e;

  // Decoder FSM
  typedef enum logic {
    ST_IDLE,
    ST_COLLECT
  } dec_state_e;

endpackage

/* hw/gat_config.svh */
`ifndef GAT_CONFIG_SVH
`define GAT_CONFIG_SVH

// Vector geometry
`define GAT_NUM_FEAT 4
`define GAT_ELEM_W 8

// Score and coefficient widths
`define GAT_SCORE_W 18
`define GAT_COEF_W 8

// Aggregation accumulator element width
`define GAT_ACC_W 24

// Largest subgraph the decoder will collect
`define GAT_MAX_NEIGH 8

// Raw score to coefficient scaling
`define GAT_SCORE_SHIFT 4

// Negative slope of the LeakyReLU, as a right shift
`define GAT_LEAKY_SHIFT 3

`endif

/* hw/gat_data_pkg.sv */
`include "gat_config.svh"

package gat_data_pkg;

  // One projected feature element
  typedef logic signed [`GAT_ELEM_W-1:0] feat_elem_t;

  // Wh vector, also the layout of an attention half
  typedef feat_elem_t [`GAT_NUM_FEAT-1:0] feat_vec_t;

  // Dot product of one attention half with one Wh vector
  typedef logic signed [`GAT_SCORE_W-1:0] score_t;

  // Clipped, unnormalised attention coefficient
  typedef logic signed [`GAT_COEF_W-1:0] coef_t;

  // Aggregated output
  typedef logic signed [`GAT_ACC_W-1:0] acc_elem_t;
  typedef acc_elem_t [`GAT_NUM_FEAT-1:0] acc_vec_t;

endpackage

/* sim/gat_attn_assertions.sv */
`include "gat_config.svh"

module gat_attn_assertions
  import gat_cmd_pkg::*;
  import gat_data_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input logic      cmd_valid_i,
  input logic      cmd_ready_o,
  input gat_op_e   cmd_op_i,
  input feat_vec_t cmd_data_i,
  input logic      out_valid_o,
  input logic      out_ready_i,
  input acc_vec_t  out_data_o
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // Reference coefficient, straight from the scoring rule
  function automatic int coef_of(input feat_vec_t as, input feat_vec_t tg,
                                 input feat_vec_t an, input feat_vec_t nb);
    int raw;
    int c;
    raw = 0;
    for (int k = 0; k < `GAT_NUM_FEAT; k++) begin
      raw = raw + int'(as[k]) * int'(tg[k]) + int'(an[k]) * int'(nb[k]);
    end
    if (raw < 0) begin
      raw = raw >>> `GAT_LEAKY_SHIFT;
    end
    c = raw >>> `GAT_SCORE_SHIFT;
    if (c > 127) c = 127;
    if (c < -128) c = -128;
    return c;
  endfunction

  dec_state_e st_m;
  int         cnt_m;
  feat_vec_t  a_self_m;
  feat_vec_t  a_neigh_m;
  feat_vec_t  tgt_m;
  int         sum_m [`GAT_NUM_FEAT];
  int         sum_next [`GAT_NUM_FEAT];
  int         coef_now;
  acc_vec_t   exp_mem [64];
  acc_vec_t   exp_head;
  int         wr_ptr;
  int         rd_ptr;
  logic       seen_last;
  logic       cmd_fire;
  logic       out_fire;
  logic       is_neigh;
  logic       last_m;

  assign cmd_fire = cmd_valid_i && cmd_ready_o;
  assign out_fire = out_valid_o && out_ready_i;
  assign is_neigh = (cmd_op_i == OP_NEIGH) || (cmd_op_i == OP_NEIGH_LAST);
  assign last_m   = (cmd_op_i == OP_NEIGH_LAST) || (cnt_m == `GAT_MAX_NEIGH - 1);
  assign exp_head = exp_mem[rd_ptr % 64];

  always_comb begin
    coef_now = coef_of(a_self_m, tgt_m, a_neigh_m, cmd_data_i);
    for (int k = 0; k < `GAT_NUM_FEAT; k++) begin
      sum_next[k] = sum_m[k] + coef_now * int'(cmd_data_i[k]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      st_m      <= ST_IDLE;
      cnt_m     <= 0;
      a_self_m  <= '0;
      a_neigh_m <= '0;
      tgt_m     <= '0;
      wr_ptr    <= 0;
      rd_ptr    <= 0;
      seen_last <= 1'b0;
      for (int k = 0; k < `GAT_NUM_FEAT; k++) sum_m[k] <= 0;
    end else begin
      if (out_fire) rd_ptr <= rd_ptr + 1;
      if (cmd_fire) begin
        case (cmd_op_i)
          OP_SET_A_SELF:  a_self_m  <= cmd_data_i;
          OP_SET_A_NEIGH: a_neigh_m <= cmd_data_i;
          OP_TARGET: begin
            st_m  <= ST_COLLECT;
            cnt_m <= 0;
            tgt_m <= cmd_data_i;
          end
          default: ;
        endcase
        if (is_neigh && st_m == ST_COLLECT) begin
          if (last_m) begin
            for (int k = 0; k < `GAT_NUM_FEAT; k++) begin
              exp_mem[wr_ptr % 64][k] <= acc_elem_t'(sum_next[k]);
              sum_m[k] <= 0;
            end
            wr_ptr    <= wr_ptr + 1;
            st_m      <= ST_IDLE;
            cnt_m     <= 0;
            seen_last <= 1'b1;
          end else begin
            for (int k = 0; k < `GAT_NUM_FEAT; k++) sum_m[k] <= sum_next[k];
            cnt_m <= cnt_m + 1;
          end
        end
      end
    end
  end

  a_quiet_before_last: assert property (@(posedge clk) disable iff (!rst_n)
    !seen_last |-> !out_valid_o)
    else begin
      fail_count++;
      $error("Output became valid before any subgraph was completed");
    end

  a_result_pending: assert property (@(posedge clk) disable iff (!rst_n)
    out_fire |-> (rd_ptr != wr_ptr))
    else begin
      fail_count++;
      $error("Output delivered with no subgraph outstanding");
    end

  a_result_value: assert property (@(posedge clk) disable iff (!rst_n)
    out_fire |-> (out_data_o == exp_head))
    else begin
      fail_count++;
      $error("Mismatch at %0t: output %h, model %h", $time, out_data_o, exp_head);
    end

  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o)))
    else begin
      fail_count++;
      $error("Output changed or dropped while stalled");
    end

  a_neigh_in_subgraph: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_fire && is_neigh) |-> (st_m == ST_COLLECT))
    else begin
      fail_count++;
      $error("Neighbour command sent outside a subgraph");
    end

endmodule

bind gat_attn_top gat_attn_assertions u_chk (.*);

/* sim/gat_attn_tb.sv */
module gat_attn_tb
  import gat_cmd_pkg::*;
  import gat_data_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  logic      clk;
  logic      rst_n;
  logic      cmd_valid_i;
  logic      cmd_ready_o;
  gat_op_e   cmd_op_i;
  feat_vec_t cmd_data_i;
  logic      out_valid_o;
  logic      out_ready_i;
  acc_vec_t  out_data_o;

  logic      hold_out;
  int        timeouts;
  int        subgraphs_sent;
  int        results_seen;
  int        count_err;
  int        total_err;

  tb_clock_gen u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  gat_attn_top dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_op_i    (cmd_op_i),
    .cmd_data_i  (cmd_data_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data_o)
  );

  always @(posedge clk) begin
    if (rst_n && out_valid_o && out_ready_i) results_seen++;
  end

  // Random back-pressure on the result channel
  initial begin
    forever begin
      @(negedge clk);
      if (!rst_n || hold_out) out_ready_i = 1'b0;
      else out_ready_i = ($urandom % 4) != 0;
    end
  end

  task automatic send_cmd(input gat_op_e op, input feat_vec_t data);
    int gap;
    int waited;
    logic done;
    gap = $urandom % 3;
    repeat (gap) @(negedge clk);
    cmd_valid_i = 1'b1;
    cmd_op_i    = op;
    cmd_data_i  = data;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < 300) begin
      @(posedge clk);
      if (cmd_ready_o) done = 1'b1;
      waited++;
      @(negedge clk);
    end
    cmd_valid_i = 1'b0;
    if (!done) begin
      timeouts++;
      $display("Timeout: command %s was not accepted by %0t", op.name(), $time);
    end
  endtask

  task automatic set_attention(input feat_vec_t a_s, input feat_vec_t a_n);
    send_cmd(OP_SET_A_SELF, a_s);
    send_cmd(OP_SET_A_NEIGH, a_n);
  endtask

  // Neighbours are random unless a fixed vector is given
  task automatic run_subgraph(input feat_vec_t tgt, input int n, input logic use_fixed,
                              input feat_vec_t fixed);
    feat_vec_t nb;
    send_cmd(OP_TARGET, tgt);
    for (int i = 0; i < n; i++) begin
      nb = use_fixed ? fixed : feat_vec_t'($urandom);
      send_cmd((i == n - 1) ? OP_NEIGH_LAST : OP_NEIGH, nb);
      if ($urandom % 5 == 0) send_cmd(OP_NOP, feat_vec_t'($urandom));
    end
    subgraphs_sent++;
  endtask

  task automatic stall_test();
    int waited;
    logic seen;
    hold_out = 1'b1;
    run_subgraph(feat_vec_t'($urandom), 2, 1'b0, '0);
    fork
      run_subgraph(feat_vec_t'($urandom), 6, 1'b0, '0);
      begin
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < 100) begin
          @(posedge clk);
          if (cmd_valid_i && !cmd_ready_o) seen = 1'b1;
          waited++;
        end
        if (!seen) begin
          timeouts++;
          $display("Timeout: command channel never stalled while output was held");
        end
        repeat (5) @(negedge clk);
        hold_out = 1'b0;
      end
    join
  endtask

  initial begin
    int waited;
    void'($urandom(32'hafd4));
    cmd_valid_i    = 1'b0;
    cmd_op_i       = OP_NOP;
    cmd_data_i     = '0;
    out_ready_i    = 1'b0;
    hold_out       = 1'b0;
    timeouts       = 0;
    subgraphs_sent = 0;
    results_seen   = 0;
    waited = 0;
    while (rst_n !== 1'b1 && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      timeouts++;
      $display("Timeout: reset was never released");
    end
    repeat (3) @(negedge clk);

    // Positive saturation
    set_attention({4{8'sd127}}, {4{8'sd127}});
    run_subgraph({4{8'sd127}}, 2, 1'b1, {4{8'sd127}});
    // Negative score through LeakyReLU into saturation
    set_attention({4{-8'sd128}}, {4{8'sd127}});
    run_subgraph({4{8'sd127}}, 3, 1'b1, {4{-8'sd128}});
    // Small negative score below saturation
    set_attention({8'sd4, 8'sd3, 8'sd2, 8'sd1}, {-8'sd5, 8'sd6, -8'sd7, 8'sd8});
    run_subgraph({8'sd20, -8'sd10, 8'sd30, -8'sd40}, 2, 1'b1,
                 {8'sd50, -8'sd60, 8'sd70, -8'sd80});

    for (int s = 0; s < 24; s++) begin
      if (s % 3 == 0) set_attention(feat_vec_t'($urandom), feat_vec_t'($urandom));
      run_subgraph(feat_vec_t'($urandom), 1 + ($urandom % 8), 1'b0, '0);
    end

    stall_test();
    run_subgraph(feat_vec_t'($urandom), 4, 1'b0, '0);

    waited = 0;
    while (results_seen != subgraphs_sent && waited < 2000) begin
      @(negedge clk);
      waited++;
    end
    if (results_seen != subgraphs_sent) begin
      timeouts++;
      $display("Timeout: only %0d of %0d results arrived", results_seen, subgraphs_sent);
    end
    repeat (5) @(negedge clk);

    count_err = (results_seen != subgraphs_sent) ? 1 : 0;
    total_err = timeouts + count_err + dut_i.u_chk.fail_count;
    $display("timeouts=%0d result_count_errors=%0d assertion_failures=%0d",
             timeouts, count_err, dut_i.u_chk.fail_count);
    if (total_err == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* sim/tb_clock_gen.sv */
module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset released on a falling edge after 16 cycles
  initial begin
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule
